// ==== source/noc_defs.svh ====
/*
 * Flit merge stage parameters
 * Payload width, channel count and per-channel buffer depth
 */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Payload bits carried by every flit
`define NOC_DATA_WIDTH 32

// Default number of merged input channels
`define NOC_CHANNELS 3

// Entries per input buffer, keep a power of two
`define NOC_BUF_DEPTH 4

`endif

// ==== source/noc_flit_pkg.sv ====
/*
 * Flit format package
 * Kind encoding and the packed flit carried on every link
 */
`include "noc_defs.svh"

package noc_flit_pkg;

   // Kind bits are {last, first}
   // so a single flit is both first and last of its worm
   typedef enum logic [1:0] {
      kind_body   = 2'b00,
      kind_head   = 2'b01,
      kind_tail   = 2'b10,
      kind_single = 2'b11
   } flit_kind_e;

   // Kind sits above the payload, 34 bits with the default width
   typedef struct packed {
      flit_kind_e                 kind;
      logic [`NOC_DATA_WIDTH-1:0] data;
   } flit_t;

endpackage

// ==== source/noc_ctrl_pkg.sv ====
/*
 * Merge control package
 * Multiplexer state and the one-hot grant vector
 */
`include "noc_defs.svh"

package noc_ctrl_pkg;

   // idle means no open worm and worm means one channel holds the output link
   typedef enum logic {
      mux_idle = 1'b0,
      mux_worm = 1'b1
   } mux_state_e;

   // One bit per channel with at most one set
   typedef logic [`NOC_CHANNELS-1:0] grant_t;

endpackage

// ==== source/noc_flit_if.sv ====
/*
 * Flit link
 * Valid/ready transfer of one flit per cycle
 */
`timescale 1ns/100ps

interface noc_flit_if;
   import noc_flit_pkg::*;

   // Payload and kind, held stable while valid waits for ready
   flit_t flit;
   // Sender has a flit on the link
   logic  valid;
   // Receiver takes the flit this cycle
   logic  ready;

   modport sender (
      output flit,
      output valid,
      input  ready
   );

   modport receiver (
      input  flit,
      input  valid,
      output ready
   );

endinterface

// ==== source/noc_rr_arbiter.sv ====
/*
 * Round-robin arbiter
 * Grants the first requester above the last winner, wrapping around
 * Priority moves only when the caller advances it
 */
`timescale 1ns/100ps

module noc_rr_arbiter (
   input  logic                 clk,
   input  logic                 rst,
   input  noc_ctrl_pkg::grant_t req,
   input  logic                 advance,
   output noc_ctrl_pkg::grant_t gnt
);
   import noc_ctrl_pkg::*;

   localparam int N = $bits(grant_t);

   // Last winner, one-hot
   grant_t prev;
   // Channels strictly above the last winner
   grant_t upper_mask;
   grant_t upper_req;

   // prev is never zero, so prev-1 marks the bits below it
   assign upper_mask = ~(prev | (prev - 1'b1));
   assign upper_req  = req & upper_mask;

   // Lowest set bit of the upper requests, else wrap to the lowest request
   always_comb begin
      if (|upper_req) begin
         gnt = upper_req & (~upper_req + 1'b1);
      end else begin
         gnt = req & (~req + 1'b1);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         // Top channel as last winner, search starts at channel 0
         prev <= grant_t'(1) << (N - 1);
      end else if (advance && (|gnt)) begin
         prev <= gnt;
      end
   end

   // Grant names at most one channel and only one that asked
   a_gnt_legal: assert property (@(posedge clk) disable iff (rst)
      $onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

// ==== source/noc_buffer.sv ====
/*
 * Per-channel flit buffer
 * Circular FIFO, oldest entry falls through to the output
 * Input ready drops when all entries are taken
 */
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_buffer #(
   parameter int DEPTH = `NOC_BUF_DEPTH
) (
   input  logic                clk,
   input  logic                rst,
   input  noc_flit_pkg::flit_t in_flit,
   input  logic                in_valid,
   output logic                in_ready,
   noc_flit_if.sender          out
);
   import noc_flit_pkg::*;

   // Pointers wrap on their own as DEPTH is a power of two
   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   flit_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   // Occupancy from 0 to DEPTH
   logic [CW-1:0] count;
   logic          wr_en;
   logic          rd_en;

   assign in_ready = (count != CW'(DEPTH));
   assign wr_en    = in_valid && in_ready;

   // Head of queue is on the link as soon as it is stored
   assign out.valid = (count != '0);
   assign out.flit  = mem[rd_ptr];
   assign rd_en     = out.valid && out.ready;

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves the count alone
         count <= count + CW'(wr_en) - CW'(rd_en);
      end
   end

   // Equal pointers on a write mean an empty buffer, never a full one
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      wr_en && (wr_ptr == rd_ptr) |-> count == '0);

   // Equal pointers on a read mean a full buffer, never an empty one
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      rd_en && (wr_ptr == rd_ptr) |-> count == CW'(DEPTH));

endmodule

// ==== source/noc_mux.sv ====
/*
 * Worm-preserving flit multiplexer
 * Round-robin pick among the input links on head or single flits
 * Winner of a head flit keeps the output until its tail has passed
 */
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_mux #(
   parameter int CHANNELS = `NOC_CHANNELS
) (
   input  logic         clk,
   input  logic         rst,
   noc_flit_if.receiver in [CHANNELS],
   noc_flit_if.sender   out
);
   import noc_flit_pkg::*;
   import noc_ctrl_pkg::*;

   mux_state_e          state;
   // Channel picked in idle, the lock owner in worm
   grant_t              held;
   // Flit presented in idle and not taken yet
   logic                pending;
   logic                locked;
   logic [CHANNELS-1:0] valid_vec;
   flit_t               ch_flit [CHANNELS];
   grant_t              req;
   grant_t              gnt;
   grant_t              sel;
   flit_t               cur_flit;
   logic                accept;
   logic                advance;

   if (CHANNELS > $bits(grant_t)) begin : g_width_check
      $error("noc_mux: CHANNELS exceeds the grant width");
   end

   // Flatten the link array
   for (genvar c = 0; c < CHANNELS; c++) begin : g_ch
      assign valid_vec[c] = in[c].valid;
      assign ch_flit[c]   = in[c].flit;
      // Only the selected channel sees ready
      assign in[c].ready  = sel[c] & out.ready;
   end

   // Open worm or waiting flit pins the choice to held
   assign locked = (state == mux_worm) || pending;
   // While pinned only held may request, so the arbiter agrees with it
   assign req    = locked ? (held & grant_t'(valid_vec)) : grant_t'(valid_vec);
   assign sel    = locked ? held : gnt;

   always_comb begin
      cur_flit = '0;
      for (int c = 0; c < CHANNELS; c++) begin
         if (sel[c]) begin
            cur_flit = ch_flit[c];
         end
      end
   end

   // Combinational path, no added cycle
   assign out.flit  = cur_flit;
   assign out.valid = |(sel & grant_t'(valid_vec));
   assign accept    = out.valid && out.ready;

   // Priority rotates once per worm start
   assign advance = accept && (cur_flit.kind == kind_head || cur_flit.kind == kind_single);

   noc_rr_arbiter u_arb (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .advance (advance),
      .gnt     (gnt)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= mux_idle;
         held    <= '0;
         pending <= 1'b0;
      end else begin
         case (state)
            mux_idle: begin
               if (out.valid) begin
                  held    <= sel;
                  pending <= !out.ready;
                  // Accepted head opens the worm
                  if (out.ready && cur_flit.kind == kind_head) begin
                     state <= mux_worm;
                  end
               end
            end
            mux_worm: begin
               // Lock ends with the tail
               if (accept && cur_flit.kind == kind_tail) begin
                  state <= mux_idle;
               end
            end
            default: state <= mux_idle;
         endcase
      end
   end

   // Stalled output keeps its flit, buffer and lock together
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      out.valid && !out.ready |=> out.valid && $stable(out.flit));

   // No second head inside an open worm
   a_no_head_in_worm: assert property (@(posedge clk) disable iff (rst)
      (state == mux_worm) && accept |-> cur_flit.kind != kind_head);

endmodule

// ==== source/noc_merge.sv ====
/*
 * Flit merge stage top level
 * One buffer per input channel feeding a worm-preserving multiplexer
 */
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_merge #(
   parameter int CHANNELS = `NOC_CHANNELS
) (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic [CHANNELS-1:0][`NOC_DATA_WIDTH-1:0]   in_data,
   input  noc_flit_pkg::flit_kind_e [CHANNELS-1:0]    in_kind,
   input  logic [CHANNELS-1:0]                        in_valid,
   output logic [CHANNELS-1:0]                        in_ready,
   output logic [`NOC_DATA_WIDTH-1:0]                 out_data,
   output noc_flit_pkg::flit_kind_e                   out_kind,
   output logic                                       out_valid,
   input  logic                                       out_ready
);
   import noc_flit_pkg::*;

   // Buffer to multiplexer links
   noc_flit_if links [CHANNELS] ();
   // Multiplexer output link
   noc_flit_if out_link ();

   for (genvar c = 0; c < CHANNELS; c++) begin : g_buf
      flit_t in_flit;

      // Pack the flat input fields
      assign in_flit.kind = in_kind[c];
      assign in_flit.data = in_data[c];

      noc_buffer #(
         .DEPTH (`NOC_BUF_DEPTH)
      ) u_buf (
         .clk      (clk),
         .rst      (rst),
         .in_flit  (in_flit),
         .in_valid (in_valid[c]),
         .in_ready (in_ready[c]),
         .out      (links[c].sender)
      );
   end

   noc_mux #(
      .CHANNELS (CHANNELS)
   ) u_mux (
      .clk (clk),
      .rst (rst),
      .in  (links),
      .out (out_link.sender)
   );

   // Break the output link out to flat ports
   assign out_data       = out_link.flit.data;
   assign out_kind       = out_link.flit.kind;
   assign out_valid      = out_link.valid;
   assign out_link.ready = out_ready;

endmodule

// ==== dv/noc_merge_tb.sv ====
/*
 * Flit merge stage testbench
 * Random worms on every channel checked against per-channel reference queues
 * Directed round-robin, buffer fill and reset checks
 */
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_merge_tb;
   import noc_flit_pkg::*;
   import noc_ctrl_pkg::*;

   localparam int CHANNELS = `NOC_CHANNELS;
   localparam int DW       = `NOC_DATA_WIDTH;
   localparam int PKTS     = 24;
   localparam int MAX_LEN  = 5;
   // Upper bound on flits over random worms, two fairness loads and one overfill
   localparam int TOTAL_FLITS    = CHANNELS * PKTS * MAX_LEN + 2 * CHANNELS
                                   + `NOC_BUF_DEPTH + 1;
   localparam int FILL_CYCLES    = 4 * CHANNELS * `NOC_BUF_DEPTH;
   localparam int TIMEOUT_CYCLES = 4 * TOTAL_FLITS + FILL_CYCLES;

   logic                        clk;
   logic                        rst;
   logic [CHANNELS-1:0][DW-1:0] in_data;
   flit_kind_e [CHANNELS-1:0]   in_kind;
   logic [CHANNELS-1:0]         in_valid;
   logic [CHANNELS-1:0]         in_ready;
   logic [DW-1:0]               out_data;
   flit_kind_e                  out_kind;
   logic                        out_valid;
   logic                        out_ready;

   integer seed = 32'h212b;
   // Reference model of the flits taken at each input in order
   flit_t  exp_q [CHANNELS][$];
   // Flits offered and flits taken per channel
   int     offered [CHANNELS];
   int     acc_cnt [CHANNELS];
   int     pkt_rem [CHANNELS];
   int     pkts_left [CHANNELS];
   int     last_winner;
   int     open_ch;
   logic   stall_prev;
   flit_t  stall_flit;
   int     cycles;

   noc_merge UUT (
      .clk       (clk),
      .rst       (rst),
      .in_data   (in_data),
      .in_kind   (in_kind),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_data  (out_data),
      .out_kind  (out_kind),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic compare_flit(string name, flit_t actual, flit_t expected);
      if (actual !== expected) begin
         abort_run($sformatf("mismatch at %0t: %s got %s/%h, expected %s/%h", $time, name,
                             actual.kind.name(), actual.data,
                             expected.kind.name(), expected.data));
      end
   endtask

   task automatic compare_grant(string name, grant_t actual, grant_t expected);
      if (actual !== expected) begin
         abort_run($sformatf("mismatch at %0t: %s got %b, expected %b",
                             $time, name, actual, expected));
      end
   endtask

   task automatic compare_level(string name, logic [CHANNELS-1:0] actual,
                                logic [CHANNELS-1:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("mismatch at %0t: %s got %b, expected %b",
                             $time, name, actual, expected));
      end
   endtask

   task automatic compare_count(string name, int actual, int expected);
      if (actual != expected) begin
         abort_run($sformatf("mismatch at %0t: %s got %0d, expected %0d",
                             $time, name, actual, expected));
      end
   endtask

   // Channel number lives in the top four data bits
   function automatic int source_of(logic [DW-1:0] data);
      return int'(data[DW-1 -: 4]);
   endfunction

   function automatic grant_t onehot(int c);
      return grant_t'(1) << c;
   endfunction

   // Next flit expected from a channel is the oldest one it accepted
   function automatic flit_t expected_flit(int c);
      return exp_q[c][0];
   endfunction

   // First requester searching upward from the one after the last winner
   function automatic int rr_next(int last, grant_t mask);
      int c;
      for (int i = 1; i <= CHANNELS; i++) begin
         c = (last + i) % CHANNELS;
         if (mask[c]) begin
            return c;
         end
      end
      return -1;
   endfunction

   function automatic bit queues_empty();
      for (int c = 0; c < CHANNELS; c++) begin
         if (exp_q[c].size() != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Output checks first, then record this edge's input transfers
   always @(posedge clk) begin : check_out
      flit_t cur;
      flit_t inf;
      int    src;
      cur.kind = out_kind;
      cur.data = out_data;
      if (rst) begin
         // Arbiter favors channel 0 after reset
         last_winner = CHANNELS - 1;
         open_ch     = -1;
         stall_prev  = 1'b0;
      end else begin
         // Stalled output holds its flit
         if (stall_prev) begin
            compare_level("out_valid", out_valid, 1'b1);
            compare_flit("out_data/out_kind", cur, stall_flit);
         end
         if (out_valid && out_ready) begin
            src = source_of(out_data);
            if (src >= CHANNELS || exp_q[src].size() == 0) begin
               abort_run($sformatf("output flit %h at %0t matches no flit sent on any channel",
                                   out_data, $time));
            end else begin
               compare_flit("out_data/out_kind", cur, expected_flit(src));
               void'(exp_q[src].pop_front());
               // Open worm owns the link until its tail
               if (open_ch >= 0) begin
                  compare_grant("worm owner", onehot(src), onehot(open_ch));
               end
               if (cur.kind == kind_head) begin
                  open_ch = src;
               end else if (cur.kind == kind_tail) begin
                  open_ch = -1;
               end
               if (cur.kind == kind_head || cur.kind == kind_single) begin
                  last_winner = src;
               end
            end
         end
         stall_prev = out_valid && !out_ready;
         stall_flit = cur;
         for (int c = 0; c < CHANNELS; c++) begin
            if (in_valid[c] && in_ready[c]) begin
               inf.kind = in_kind[c];
               inf.data = in_data[c];
               exp_q[c].push_back(inf);
               acc_cnt[c] = acc_cnt[c] + 1;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         abort_run($sformatf("timeout, run still busy after %0d cycles", cycles));
      end
   end

   // Sequence number in the low bits and source channel on top
   task automatic drive_flit(int c, flit_kind_e kind);
      in_kind[c]  = kind;
      in_data[c]  = (DW'(c) << (DW - 4)) | DW'(offered[c]);
      in_valid[c] = 1'b1;
      offered[c]  = offered[c] + 1;
   endtask

   // Hold each offer until taken, then drop valid
   task automatic finish_offers();
      bit busy;
      busy = 1'b1;
      while (busy) begin
         @(negedge clk);
         busy = 1'b0;
         for (int c = 0; c < CHANNELS; c++) begin
            if (acc_cnt[c] == offered[c]) begin
               in_valid[c] = 1'b0;
            end else begin
               busy = 1'b1;
            end
         end
      end
   endtask

   task automatic wait_drain();
      while (!queues_empty()) begin
         @(negedge clk);
      end
   endtask

   // One single flit per channel in mask with the output stalled
   task automatic load_singles(grant_t mask);
      @(negedge clk);
      out_ready = 1'b0;
      for (int c = 0; c < CHANNELS; c++) begin
         if (mask[c]) begin
            drive_flit(c, kind_single);
         end
      end
      finish_offers();
      repeat (2) @(negedge clk);
   endtask

   // Release the stall and expect winners in rotating order
   task automatic check_round_robin(grant_t mask);
      grant_t left;
      int     prev;
      int     src;
      int     exp_ch;
      left      = mask;
      prev      = last_winner;
      out_ready = 1'b1;
      while (left != '0) begin
         @(posedge clk);
         if (out_valid && out_ready) begin
            src    = source_of(out_data);
            exp_ch = rr_next(prev, left);
            compare_grant("round-robin winner", onehot(src), onehot(exp_ch));
            left[src] = 1'b0;
            prev      = src;
         end
      end
      @(negedge clk);
      out_ready = 1'b0;
   endtask

   // Channel c keeps offering into a stalled output until its buffer is full
   task automatic overfill(int c);
      int start;
      start = acc_cnt[c];
      @(negedge clk);
      out_ready = 1'b0;
      drive_flit(c, kind_single);
      repeat (`NOC_BUF_DEPTH + 3) begin
         @(negedge clk);
         if (acc_cnt[c] == offered[c]) begin
            drive_flit(c, kind_single);
         end
      end
      compare_count("flits accepted before in_ready drops", acc_cnt[c] - start,
                    `NOC_BUF_DEPTH);
      compare_level("in_ready", in_ready[c], 1'b0);
      out_ready = 1'b1;
      finish_offers();
      wait_drain();
   endtask

   // Random-length worms with gaps and random output stalls
   task automatic random_traffic();
      flit_kind_e kind;
      int         len;
      bit         busy;
      for (int c = 0; c < CHANNELS; c++) begin
         pkts_left[c] = PKTS;
         pkt_rem[c]   = 0;
      end
      busy = 1'b1;
      while (busy) begin
         @(negedge clk);
         busy      = 1'b0;
         out_ready = ({$random(seed)} % 4) != 0;
         for (int c = 0; c < CHANNELS; c++) begin
            if (in_valid[c] && acc_cnt[c] != offered[c]) begin
               busy = 1'b1;
            end else begin
               in_valid[c] = 1'b0;
               if ((pkts_left[c] > 0 || pkt_rem[c] > 0) && ({$random(seed)} % 4) != 0) begin
                  if (pkt_rem[c] == 0) begin
                     len          = 1 + ({$random(seed)} % MAX_LEN);
                     pkts_left[c] = pkts_left[c] - 1;
                     kind         = (len == 1) ? kind_single : kind_head;
                     pkt_rem[c]   = len - 1;
                  end else begin
                     kind       = (pkt_rem[c] == 1) ? kind_tail : kind_body;
                     pkt_rem[c] = pkt_rem[c] - 1;
                  end
                  drive_flit(c, kind);
               end
               if (in_valid[c] || pkts_left[c] > 0 || pkt_rem[c] > 0) begin
                  busy = 1'b1;
               end
            end
         end
      end
   endtask

   initial begin : main_seq
      rst       = 1'b1;
      out_ready = 1'b0;
      in_valid  = '0;
      in_data   = '0;
      for (int c = 0; c < CHANNELS; c++) begin
         in_kind[c] = kind_body;
      end
      cycles = 0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      compare_level("in_ready", in_ready, '1);
      compare_level("out_valid", out_valid, 1'b0);
      // Fresh pointer starts at channel 0
      load_singles('1);
      check_round_robin('1);
      overfill(0);
      // Channel 0 won last, so the next load starts at channel 1
      load_singles('1);
      check_round_robin('1);
      random_traffic();
      @(negedge clk);
      out_ready = 1'b1;
      wait_drain();
      repeat (2) @(negedge clk);
      if (queues_empty() && !out_valid && in_ready == '1) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         abort_run("flits still in flight after the final drain");
      end
   end

endmodule

// ==== filelist.f ====
+incdir+source
source/noc_flit_pkg.sv
source/noc_ctrl_pkg.sv
source/noc_flit_if.sv
source/noc_rr_arbiter.sv
source/noc_buffer.sv
source/noc_mux.sv
source/noc_merge.sv
dv/noc_merge_tb.sv

// ==== Bender.yml ====
package:
  name: noc_merge

export_include_dirs:
  - source

sources:
  # Packages, interface and RTL in compile order
  - include_dirs:
      - source
    files:
      - source/noc_flit_pkg.sv
      - source/noc_ctrl_pkg.sv
      - source/noc_flit_if.sv
      - source/noc_rr_arbiter.sv
      - source/noc_buffer.sv
      - source/noc_mux.sv
      - source/noc_merge.sv

  # Testbench
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/noc_merge_tb.sv
